//--- hw/fetch_pkg.sv
package fetch_pkg;

    // datapath width
    localparam int XLEN = 32;

    // cache geometry
    localparam int LINE_WORDS = 4;
    localparam int LINE_BYTES = LINE_WORDS * (XLEN / 8);
    localparam int NUM_LINES  = 16;

    // address fields
    localparam int OFFSET_W   = $clog2(LINE_BYTES);
    localparam int WORD_W     = $clog2(LINE_WORDS);
    localparam int BYTE_OFF_W = OFFSET_W - WORD_W;  // byte within a word
    localparam int INDEX_W    = $clog2(NUM_LINES);
    localparam int TAG_W      = XLEN - OFFSET_W - INDEX_W;

    // read response
    localparam int              RESP_W    = 2;
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // register block
    localparam int CSR_ADDR_W = 2;

    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL   = CSR_ADDR_W'(0);
    localparam logic [CSR_ADDR_W-1:0] CSR_HITS   = CSR_ADDR_W'(1);
    localparam logic [CSR_ADDR_W-1:0] CSR_MISSES = CSR_ADDR_W'(2);

    // CSR_CTRL bits
    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_FLUSH_BIT = 1;  // write 1 to flush, reads 0

endpackage

//--- hw/fetch_ifu.sv
`timescale 1ns/100ps

module fetch_ifu (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [fetch_pkg::XLEN-1:0]     pc,
    input  logic                           idu_ready,
    output logic                           ifu_valid,
    output logic [fetch_pkg::XLEN-1:0]     inst,

    output logic [fetch_pkg::XLEN-1:0]     araddr,
    output logic                           arvalid,
    input  logic                           arready,

    input  logic [fetch_pkg::XLEN-1:0]     rdata,
    input  logic [fetch_pkg::RESP_W-1:0]   rresp,
    input  logic                           rvalid,
    output logic                           rready,

    output logic                           lookup_req,
    output logic [fetch_pkg::XLEN-1:0]     lookup_addr,
    input  logic                           hit,
    input  logic [fetch_pkg::XLEN-1:0]     lookup_data,

    output logic                           refill_we,
    output logic [fetch_pkg::XLEN-1:0]     refill_addr,
    output logic [fetch_pkg::XLEN-1:0]     refill_word,
    output logic                           refill_last,

    output logic                           hit_event,
    output logic                           miss_event
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        REFILL,
        DELIVER
    } state_t;

    state_t            state;
    logic [XLEN-1:0]   last_pc;
    logic [XLEN-1:0]   line_base;
    logic              accept;
    logic              beat_done;
    logic              beat_ok;
    logic [WORD_W-1:0] beat_idx;
    logic              beat_last;
    logic              beat_match;

    // new fetch only when pc moved and decode can take it
    assign accept     = (state == IDLE) && (pc != last_pc) && idu_ready;
    assign line_base  = {last_pc[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign beat_done  = rvalid && rready;
    assign beat_ok    = (rresp == RESP_OKAY);
    assign beat_idx   = araddr[BYTE_OFF_W +: WORD_W];
    assign beat_last  = (beat_idx == WORD_W'(LINE_WORDS - 1));
    assign beat_match = (beat_idx == last_pc[BYTE_OFF_W +: WORD_W]);

    assign lookup_addr = last_pc;  // updated on the same edge as lookup_req

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            last_pc     <= '0;
            ifu_valid   <= 1'b0;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            lookup_req  <= 1'b0;
            refill_we   <= 1'b0;
            refill_last <= 1'b0;
            hit_event   <= 1'b0;
            miss_event  <= 1'b0;
        end else begin
            // strobes
            lookup_req  <= 1'b0;
            refill_we   <= 1'b0;
            refill_last <= 1'b0;
            hit_event   <= 1'b0;
            miss_event  <= 1'b0;

            case (state)
                IDLE: begin
                    if (accept) begin
                        last_pc    <= pc;
                        lookup_req <= 1'b1;
                        state      <= CHECK;
                    end
                end
                CHECK: begin
                    // first cycle is the lookup itself, result follows
                    if (!lookup_req) begin
                        if (hit) begin
                            hit_event <= 1'b1;
                            ifu_valid <= 1'b1;
                            state     <= DELIVER;
                        end else begin
                            miss_event <= 1'b1;
                            arvalid    <= 1'b1;
                            state      <= REFILL;
                        end
                    end
                end
                REFILL: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (beat_done) begin
                        rready <= 1'b0;
                        if (beat_ok) begin
                            refill_we   <= 1'b1;
                            refill_last <= beat_last;
                            if (beat_last) begin
                                ifu_valid <= 1'b1;
                                state     <= DELIVER;
                            end else begin
                                arvalid <= 1'b1;  // next word
                            end
                        end else begin
                            arvalid <= 1'b1;  // retry same word
                        end
                    end
                end
                DELIVER: begin
                    if (idu_ready) begin
                        ifu_valid <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        case (state)
            CHECK: begin
                if (!lookup_req) begin
                    if (hit) begin
                        inst <= lookup_data;
                    end else begin
                        araddr <= line_base;
                    end
                end
            end
            REFILL: begin
                if (beat_done && beat_ok) begin
                    refill_addr <= araddr;
                    refill_word <= rdata;
                    if (beat_match) begin
                        inst <= rdata;  // the word decode asked for
                    end
                    if (!beat_last) begin
                        araddr <= araddr + XLEN'(XLEN / 8);
                    end
                end
            end
            default: ;
        endcase
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    valid_hold: assert property (@(posedge clk) disable iff (rst)
        ifu_valid && !idu_ready |=> ifu_valid && $stable(inst));

endmodule

//--- hw/icache_array.sv
`timescale 1ns/100ps

module icache_array (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        lookup_req,
    input  logic [fetch_pkg::XLEN-1:0]  lookup_addr,
    output logic                        hit,
    output logic [fetch_pkg::XLEN-1:0]  lookup_data,

    input  logic                        refill_we,
    input  logic [fetch_pkg::XLEN-1:0]  refill_addr,
    input  logic [fetch_pkg::XLEN-1:0]  refill_word,
    input  logic                        refill_last,

    input  logic                        enable,
    input  logic                        flush
);
    import fetch_pkg::*;

    // storage
    logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
    logic [XLEN-1:0]      data_mem [NUM_LINES * LINE_WORDS];
    logic [NUM_LINES-1:0] valid;

    // lookup fields
    logic [INDEX_W-1:0]   lk_index;
    logic [WORD_W-1:0]    lk_word;
    logic [TAG_W-1:0]     lk_tag;
    logic                 lk_match;

    // refill fields
    logic [INDEX_W-1:0]   rf_index;
    logic [WORD_W-1:0]    rf_word;
    logic [TAG_W-1:0]     rf_tag;

    assign lk_index = lookup_addr[OFFSET_W +: INDEX_W];
    assign lk_word  = lookup_addr[BYTE_OFF_W +: WORD_W];
    assign lk_tag   = lookup_addr[XLEN-1 -: TAG_W];

    assign rf_index = refill_addr[OFFSET_W +: INDEX_W];
    assign rf_word  = refill_addr[BYTE_OFF_W +: WORD_W];
    assign rf_tag   = refill_addr[XLEN-1 -: TAG_W];

    // disabled cache never hits
    assign lk_match = enable && valid[lk_index] && (tag_mem[lk_index] == lk_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit   <= 1'b0;
            valid <= '0;
        end else begin
            if (lookup_req) begin
                hit <= lk_match;
            end
            // flush beats a line completing in the same cycle
            if (flush) begin
                valid <= '0;
            end else if (refill_we && refill_last && enable) begin
                valid[rf_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req) begin
            lookup_data <= data_mem[{lk_index, lk_word}];
        end
        if (refill_we) begin
            data_mem[{rf_index, rf_word}] <= refill_word;
            if (refill_last) begin
                tag_mem[rf_index] <= rf_tag;  // tag goes in with the last word
            end
        end
    end

    // fetch unit serializes lookup and refill
    no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(refill_we && lookup_req));

endmodule

//--- hw/icache_csr.sv
`timescale 1ns/100ps

module icache_csr (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              csr_wr,
    input  logic [fetch_pkg::CSR_ADDR_W-1:0]  csr_addr,
    input  logic [fetch_pkg::XLEN-1:0]        csr_wdata,
    output logic [fetch_pkg::XLEN-1:0]        csr_rdata,

    input  logic                              hit_event,
    input  logic                              miss_event,

    output logic                              enable,
    output logic                              flush
);
    import fetch_pkg::*;

    logic [XLEN-1:0] hits;
    logic [XLEN-1:0] misses;
    logic            ctrl_wr;
    logic            hits_clr;
    logic            misses_clr;

    assign ctrl_wr    = csr_wr && (csr_addr == CSR_CTRL);
    assign hits_clr   = csr_wr && (csr_addr == CSR_HITS);
    assign misses_clr = csr_wr && (csr_addr == CSR_MISSES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable <= 1'b0;
            flush  <= 1'b0;
            hits   <= '0;
            misses <= '0;
        end else begin
            flush <= ctrl_wr && csr_wdata[CTRL_FLUSH_BIT];  // one-cycle pulse
            if (ctrl_wr) begin
                enable <= csr_wdata[CTRL_EN_BIT];
            end

            // counters saturate at all ones
            if (hits_clr) begin
                hits <= '0;
            end else if (hit_event && (hits != '1)) begin
                hits <= hits + 1'b1;
            end

            if (misses_clr) begin
                misses <= '0;
            end else if (miss_event && (misses != '1)) begin
                misses <= misses + 1'b1;
            end
        end
    end

    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            CSR_CTRL:   csr_rdata[CTRL_EN_BIT] = enable;
            CSR_HITS:   csr_rdata = hits;
            CSR_MISSES: csr_rdata = misses;
            default:    csr_rdata = '0;
        endcase
    end

    one_event: assert property (@(posedge clk) disable iff (rst)
        !(hit_event && miss_event));

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [fetch_pkg::XLEN-1:0]        pc,
    input  logic                              idu_ready,
    output logic                              ifu_valid,
    output logic [fetch_pkg::XLEN-1:0]        inst,

    output logic [fetch_pkg::XLEN-1:0]        araddr,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [fetch_pkg::XLEN-1:0]        rdata,
    input  logic [fetch_pkg::RESP_W-1:0]      rresp,
    input  logic                              rvalid,
    output logic                              rready,

    input  logic                              csr_wr,
    input  logic [fetch_pkg::CSR_ADDR_W-1:0]  csr_addr,
    input  logic [fetch_pkg::XLEN-1:0]        csr_wdata,
    output logic [fetch_pkg::XLEN-1:0]        csr_rdata
);
    import fetch_pkg::*;

    // ifu to cache
    logic            lookup_req;
    logic [XLEN-1:0] lookup_addr;
    logic            hit;
    logic [XLEN-1:0] lookup_data;
    logic            refill_we;
    logic [XLEN-1:0] refill_addr;
    logic [XLEN-1:0] refill_word;
    logic            refill_last;

    // ifu to csr, csr to cache
    logic            hit_event;
    logic            miss_event;
    logic            enable;
    logic            flush;

    fetch_ifu u_ifu (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .idu_ready   (idu_ready),
        .ifu_valid   (ifu_valid),
        .inst        (inst),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .lookup_data (lookup_data),
        .refill_we   (refill_we),
        .refill_addr (refill_addr),
        .refill_word (refill_word),
        .refill_last (refill_last),
        .hit_event   (hit_event),
        .miss_event  (miss_event)
    );

    icache_array u_array (
        .clk         (clk),
        .rst         (rst),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .lookup_data (lookup_data),
        .refill_we   (refill_we),
        .refill_addr (refill_addr),
        .refill_word (refill_word),
        .refill_last (refill_last),
        .enable      (enable),
        .flush       (flush)
    );

    icache_csr u_csr (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .hit_event  (hit_event),
        .miss_event (miss_event),
        .enable     (enable),
        .flush      (flush)
    );

endmodule

//--- tests/fetch_mem_model.sv
`timescale 1ns/100ps

module fetch_mem_model #(
    parameter logic [31:0] KEY = 32'h0
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [fetch_pkg::XLEN-1:0]      araddr,
    input  logic                            arvalid,
    output logic                            arready,

    output logic [fetch_pkg::XLEN-1:0]      rdata,
    output logic [fetch_pkg::RESP_W-1:0]    rresp,
    output logic                            rvalid,
    input  logic                            rready
);
    import fetch_pkg::*;

    integer          seed = 66633;
    logic [XLEN-1:0] req_addr;
    logic            pending;   // address taken, beat still owed
    logic            ar_fire;
    logic            r_fire;

    // everything moves on the falling edge, handshakes complete on the next rising edge
    initial begin
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        rresp    = RESP_OKAY;
        req_addr = '0;
        pending  = 1'b0;
        ar_fire  = 1'b0;
        r_fire   = 1'b0;
        forever begin
            @(negedge clk);
            if (rst) begin
                arready = 1'b0;
                rvalid  = 1'b0;
                pending = 1'b0;
                ar_fire = 1'b0;
                r_fire  = 1'b0;
            end else begin
                if (ar_fire) begin
                    arready = 1'b0;
                    pending = 1'b1;
                end
                if (r_fire) begin
                    rvalid  = 1'b0;
                    pending = 1'b0;
                end
                // random address accept delay
                if (arvalid && !arready && !pending && (($random(seed) & 3) == 0)) begin
                    arready  = 1'b1;
                    req_addr = araddr;
                end
                if (pending && !rvalid && (($random(seed) & 1) == 0)) begin
                    rvalid = 1'b1;
                    if (($random(seed) & 7) == 0) begin
                        rresp = RESP_W'(2);          // slave error
                        rdata = ~(req_addr ^ KEY);   // garbage on a bad beat
                    end else begin
                        rresp = RESP_OKAY;
                        rdata = req_addr ^ KEY;
                    end
                end
                ar_fire = arvalid && arready;
                r_fire  = rvalid && rready;
            end
        end
    end

endmodule

//--- tests/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;
    import fetch_pkg::*;

    localparam logic [XLEN-1:0] MEM_KEY   = 32'h5a3c_96e1;
    localparam logic [XLEN-1:0] LINE_MASK = ~XLEN'(LINE_BYTES - 1);
    localparam int              WAIT_MAX  = 2000;
    localparam int              HIT_DELAY = 2;

    logic                  clk;
    logic                  rst;
    logic [XLEN-1:0]       pc;
    logic                  idu_ready;
    logic                  ifu_valid;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       araddr;
    logic                  arvalid;
    logic                  arready;
    logic [XLEN-1:0]       rdata;
    logic [RESP_W-1:0]     rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  csr_wr;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       csr_wdata;
    logic [XLEN-1:0]       csr_rdata;

    // reference cache state
    logic [TAG_W-1:0]      ref_tag [NUM_LINES];
    logic [NUM_LINES-1:0]  ref_valid;
    logic                  ref_enable;
    int                    ref_hits;
    int                    ref_misses;
    logic [XLEN-1:0]       prev_pc;
    integer                seed = 66633;

    fetch_top UUT (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .idu_ready (idu_ready),
        .ifu_valid (ifu_valid),
        .inst      (inst),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .csr_wr    (csr_wr),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata)
    );

    fetch_mem_model #(.KEY(MEM_KEY)) u_mem (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #2 clk = ~clk;

    task automatic abort(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort("value check failed");
        end
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
        @(negedge clk);
        csr_wr    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_wr = 1'b0;
    endtask

    task automatic check_csr(input logic [CSR_ADDR_W-1:0] addr, input string name,
                             input logic [XLEN-1:0] exp);
        @(negedge clk);
        csr_addr = addr;
        #1;  // combinational read settles
        check(name, csr_rdata, exp);
    endtask

    function automatic logic predict_hit(input logic [XLEN-1:0] a);
        logic [INDEX_W-1:0] idx;
        idx = a[OFFSET_W +: INDEX_W];
        return ref_enable && ref_valid[idx] && (ref_tag[idx] == a[XLEN-1 -: TAG_W]);
    endfunction

    // word aligned pc inside a region but never the one just fetched
    task automatic pick_pc(input logic [XLEN-1:0] base, input int words,
                           output logic [XLEN-1:0] a);
        a = base + XLEN'(($unsigned($random(seed)) % words) * 4);
        if (a == prev_pc) begin
            a = a ^ XLEN'(4);
        end
    endtask

    task automatic fetch(input logic [XLEN-1:0] addr);
        logic               exp_hit;
        logic               saw_ar;
        logic [INDEX_W-1:0] idx;
        int                 lat;
        int                 hold;

        exp_hit = predict_hit(addr);
        idx     = addr[OFFSET_W +: INDEX_W];
        saw_ar  = 1'b0;
        lat     = 0;
        @(negedge clk);
        pc        = addr;
        idu_ready = 1'b1;  // accepted on the next rising edge
        do begin
            @(negedge clk);
            lat++;
            if (arvalid) begin
                saw_ar = 1'b1;
                check("araddr line", araddr & LINE_MASK, addr & LINE_MASK);
                check("rready", XLEN'(rready), XLEN'(0));  // address phase first
            end
        end while (!ifu_valid && lat < WAIT_MAX);
        if (!ifu_valid) begin
            abort($sformatf("timeout waiting for ifu_valid on pc %h", addr));
        end

        check("miss", XLEN'(saw_ar), XLEN'(!exp_hit));
        if (exp_hit) begin
            check("hit latency", lat - 1, HIT_DELAY);
            ref_hits++;
        end else begin
            ref_misses++;
            ref_tag[idx] = addr[XLEN-1 -: TAG_W];  // line refilled even when disabled
            if (ref_enable) begin
                ref_valid[idx] = 1'b1;
            end
        end
        check("inst", inst, addr ^ MEM_KEY);

        // decode stall
        hold = (($random(seed) & 1) == 0) ? 0 : ($random(seed) & 7);
        if (hold > 0) begin
            idu_ready = 1'b0;
            repeat (hold) begin
                @(negedge clk);
                check("ifu_valid", XLEN'(ifu_valid), XLEN'(1));
                check("inst", inst, addr ^ MEM_KEY);
                check("arvalid", XLEN'(arvalid), XLEN'(0));
                check("rready", XLEN'(rready), XLEN'(0));
            end
            idu_ready = 1'b1;
        end
        @(negedge clk);
        check("ifu_valid", XLEN'(ifu_valid), XLEN'(0));
        prev_pc = addr;
    endtask

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] last;

        clk        = 1'b0;
        rst        = 1'b1;
        pc         = '0;
        idu_ready  = 1'b0;
        csr_wr     = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        ref_valid  = '0;
        ref_enable = 1'b0;
        ref_hits   = 0;
        ref_misses = 0;
        prev_pc    = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        check_csr(CSR_CTRL, "ctrl", 0);
        check_csr(CSR_HITS, "hits", 0);
        check_csr(CSR_MISSES, "misses", 0);

        // with the cache off every fetch goes to memory
        repeat (20) begin
            pick_pc(32'h0, 1 << 30, a);
            fetch(a);
        end
        check_csr(CSR_MISSES, "misses", 20);
        check_csr(CSR_HITS, "hits", 0);

        csr_write(CSR_HITS, $random(seed));
        csr_write(CSR_MISSES, $random(seed));
        check_csr(CSR_HITS, "hits", 0);
        check_csr(CSR_MISSES, "misses", 0);
        ref_hits   = 0;
        ref_misses = 0;

        csr_write(CSR_CTRL, 32'h1);
        ref_enable = 1'b1;
        check_csr(CSR_CTRL, "ctrl", 1);

        // 512 byte region gives two tags per index
        repeat (80) begin
            pick_pc(32'h1000, 128, a);
            fetch(a);
        end
        check_csr(CSR_HITS, "hits", ref_hits);
        check_csr(CSR_MISSES, "misses", ref_misses);

        // flush then revisit the line fetched last
        last = prev_pc;
        csr_write(CSR_CTRL, 32'h3);
        ref_valid = '0;
        check_csr(CSR_CTRL, "ctrl", 1);
        fetch(last ^ XLEN'(4));
        fetch(last);
        repeat (30) begin
            pick_pc(32'h1000, 128, a);
            fetch(a);
        end
        check_csr(CSR_HITS, "hits", ref_hits);
        check_csr(CSR_MISSES, "misses", ref_misses);

        csr_write(CSR_HITS, 32'hffff_ffff);
        csr_write(CSR_MISSES, 32'h1);
        check_csr(CSR_HITS, "hits", 0);
        check_csr(CSR_MISSES, "misses", 0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- fetch_top.f
hw/fetch_pkg.sv
hw/fetch_ifu.sv
hw/icache_array.sv
hw/icache_csr.sv
hw/fetch_top.sv
tests/fetch_mem_model.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_tb \
    -f fetch_top.f \
    --Mdir obj_dir \
    -o fetch_sim \
    && ./obj_dir/fetch_sim \
    || exit 1

exit 0
